// File: Makefile
VERILATOR ?= verilator
TOP       := tb_hash_search
FILELIST  := hash_search.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert --top-module $(TOP) -Mdir $(OBJ_DIR)
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "^Regression passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hash_search.f
rtl/hash_search_pkg.sv
rtl/pattern_store.sv
rtl/bucket_index.sv
rtl/slot_counter.sv
rtl/search_fsm.sv
rtl/distance_rank.sv
rtl/hash_search.sv
verif/hash_search_assert.sv
verif/tb_hash_search.sv

// File: rtl/bucket_index.sv
`timescale 1ns/10ps
`default_nettype none

module bucket_index (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  store_write,
    input  logic [hash_search_pkg::pattern_w-1:0] write_data,
    input  logic [hash_search_pkg::index_w-1:0]   write_index,
    input  logic [hash_search_pkg::nibble_w-1:0]  read_key_lo,
    input  logic [hash_search_pkg::nibble_w-1:0]  read_key_hi,
    input  logic                                  scan_high,
    input  logic [hash_search_pkg::slot_w-1:0]    slot,
    output logic [hash_search_pkg::fill_w-1:0]    fill_lo,
    output logic [hash_search_pkg::fill_w-1:0]    fill_hi,
    output logic [hash_search_pkg::index_w-1:0]   read_index
);

    // table 0 is keyed by the low nibble, table 1 by the high nibble.
    logic [hash_search_pkg::index_w-1:0] bucket_mem [2][hash_search_pkg::bucket_count]
                                                      [hash_search_pkg::bucket_slots];
    logic [hash_search_pkg::fill_w-1:0]   fill [2][hash_search_pkg::bucket_count];
    hash_search_pkg::pattern_word_t       word;
    logic [hash_search_pkg::nibble_w-1:0] write_key [2];
    logic [hash_search_pkg::slot_w-1:0]   write_slot [2];
    logic [1:0]                           has_room;

    assign word         = write_data;
    assign write_key[0] = word.nib.lo;
    assign write_key[1] = word.nib.hi;

    always_comb
    begin
        for (int t = 0; t < 2; t++)
        begin
            has_room[t]   = fill[t][write_key[t]] < hash_search_pkg::bucket_slots;
            write_slot[t] = fill[t][write_key[t]][hash_search_pkg::slot_w-1:0];
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int t = 0; t < 2; t++)
            begin
                for (int b = 0; b < hash_search_pkg::bucket_count; b++)
                begin
                    fill[t][b] <= '0;
                end
            end
        end
        else if (store_write)
        begin
            for (int t = 0; t < 2; t++)
            begin
                if (has_room[t])
                begin
                    fill[t][write_key[t]] <= fill[t][write_key[t]] + 1'b1;    // stops at 16.
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        for (int t = 0; t < 2; t++)
        begin
            if (store_write && has_room[t])
            begin
                bucket_mem[t][write_key[t]][write_slot[t]] <= write_index;
            end
        end
    end

    assign fill_lo    = fill[0][read_key_lo];
    assign fill_hi    = fill[1][read_key_hi];
    assign read_index = scan_high ? bucket_mem[1][read_key_hi][slot]
                                  : bucket_mem[0][read_key_lo][slot];

endmodule

`default_nettype wire

// File: rtl/distance_rank.sv
`timescale 1ns/10ps
`default_nettype none

module distance_rank (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic [hash_search_pkg::pattern_w-1:0] query_data,
    input  logic                                  candidate_valid,
    input  logic                                  candidate_high,
    input  logic [hash_search_pkg::pattern_w-1:0] candidate,
    input  logic                                  rank_clear,
    input  logic                                  rank_finish,
    output logic [hash_search_pkg::count_w-1:0]   match_count,
    output logic [hash_search_pkg::pattern_w-1:0] match0,
    output logic [hash_search_pkg::pattern_w-1:0] match1,
    output logic [hash_search_pkg::pattern_w-1:0] match2,
    output logic [hash_search_pkg::dist_w-1:0]    dist0,
    output logic [hash_search_pkg::dist_w-1:0]    dist1,
    output logic [hash_search_pkg::dist_w-1:0]    dist2
);

    hash_search_pkg::pattern_word_t         query_word;
    hash_search_pkg::pattern_word_t         cand_word;
    logic [hash_search_pkg::pattern_w-1:0]  diff;
    logic [hash_search_pkg::dist_w-1:0]     cand_dist;
    logic                                   high_q;
    logic                                   take;
    logic [hash_search_pkg::count_w-1:0]    keep_count;
    logic [hash_search_pkg::pattern_w-1:0]  keep_pat [hash_search_pkg::rank_depth];
    logic [hash_search_pkg::dist_w-1:0]     keep_dist [hash_search_pkg::rank_depth];
    logic [hash_search_pkg::rank_depth-1:0] beats;    // candidate ranks at or above entry i.
    logic [hash_search_pkg::rank_depth-1:0] lands;    // candidate is written into entry i.

    assign query_word = query_data;
    assign cand_word  = candidate;
    assign diff       = query_word.word ^ cand_word.word;

    always_comb
    begin
        cand_dist = '0;
        for (int i = 0; i < hash_search_pkg::pattern_w; i++)
        begin
            cand_dist = cand_dist + {{(hash_search_pkg::dist_w-1){1'b0}}, diff[i]};
        end
    end

    // the high flag follows the slot, so it trails by one cycle to meet the pattern.
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            high_q <= 1'b0;
        end
        else
        begin
            high_q <= candidate_high;
        end
    end

    // a high-bucket entry with our low nibble was already seen in the low bucket.
    assign take = candidate_valid && !(high_q && (cand_word.nib.lo == query_word.nib.lo));

    always_comb
    begin
        for (int i = 0; i < hash_search_pkg::rank_depth; i++)
        begin
            beats[i] = (i >= keep_count) || (cand_dist < keep_dist[i]);    // strict, ties stay.
        end
        lands[0] = beats[0];
        for (int i = 1; i < hash_search_pkg::rank_depth; i++)
        begin
            lands[i] = beats[i] && !beats[i-1];
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset || rank_clear)
        begin
            keep_count <= '0;
        end
        else if (take && (keep_count < hash_search_pkg::rank_depth))
        begin
            keep_count <= keep_count + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (take)
        begin
            if (lands[0])
            begin
                keep_pat[0]  <= candidate;
                keep_dist[0] <= cand_dist;
            end
            for (int i = 1; i < hash_search_pkg::rank_depth; i++)
            begin
                if (lands[i])
                begin
                    keep_pat[i]  <= candidate;
                    keep_dist[i] <= cand_dist;
                end
                else if (beats[i])
                begin
                    keep_pat[i]  <= keep_pat[i-1];    // shift down past the new entry.
                    keep_dist[i] <= keep_dist[i-1];
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            match_count <= '0;
        end
        else if (rank_finish)
        begin
            match_count <= keep_count;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rank_finish)
        begin
            match0 <= keep_pat[0];
            match1 <= keep_pat[1];
            match2 <= keep_pat[2];
            dist0  <= keep_dist[0];
            dist1  <= keep_dist[1];
            dist2  <= keep_dist[2];
        end
    end

endmodule

`default_nettype wire

// File: rtl/hash_search.sv
`timescale 1ns/10ps
`default_nettype none

module hash_search (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  load_valid,
    input  logic [hash_search_pkg::pattern_w-1:0] load_data,
    input  logic                                  query_start,
    input  logic [hash_search_pkg::pattern_w-1:0] query_data,
    output logic                                  busy,
    output logic                                  done,
    output logic [hash_search_pkg::count_w-1:0]   match_count,
    output logic [hash_search_pkg::pattern_w-1:0] match0,
    output logic [hash_search_pkg::pattern_w-1:0] match1,
    output logic [hash_search_pkg::pattern_w-1:0] match2,
    output logic [hash_search_pkg::dist_w-1:0]    dist0,
    output logic [hash_search_pkg::dist_w-1:0]    dist1,
    output logic [hash_search_pkg::dist_w-1:0]    dist2
);

    logic                                  store_write;
    logic [hash_search_pkg::index_w-1:0]   write_index;
    logic [hash_search_pkg::pattern_w-1:0] query_key;
    logic                                  count_start;
    logic [hash_search_pkg::fill_w-1:0]    count_fill;
    logic                                  scan_high;
    logic                                  candidate_valid;
    logic                                  rank_clear;
    logic                                  rank_finish;
    logic [hash_search_pkg::fill_w-1:0]    fill_lo;
    logic [hash_search_pkg::fill_w-1:0]    fill_hi;
    logic [hash_search_pkg::slot_w-1:0]    slot;
    logic                                  active;
    logic                                  last;
    logic [hash_search_pkg::index_w-1:0]   read_index;
    logic [hash_search_pkg::pattern_w-1:0] read_data;

    search_fsm u_fsm (
        .clk             (clk),
        .reset           (reset),
        .load_valid      (load_valid),
        .query_start     (query_start),
        .query_data      (query_data),
        .fill_lo         (fill_lo),
        .fill_hi         (fill_hi),
        .active          (active),
        .last            (last),
        .store_write     (store_write),
        .write_index     (write_index),
        .entry_full      (),
        .query_key       (query_key),
        .count_start     (count_start),
        .count_fill      (count_fill),
        .scan_high       (scan_high),
        .candidate_valid (candidate_valid),
        .rank_clear      (rank_clear),
        .rank_finish     (rank_finish),
        .busy            (busy),
        .done            (done)
    );

    slot_counter u_counter (
        .clk         (clk),
        .reset       (reset),
        .count_start (count_start),
        .count_fill  (count_fill),
        .slot        (slot),
        .active      (active),
        .last        (last)
    );

    pattern_store u_store (
        .clk         (clk),
        .store_write (store_write),
        .write_index (write_index),
        .write_data  (load_data),
        .read_index  (read_index),
        .read_data   (read_data)
    );

    bucket_index u_index (
        .clk         (clk),
        .reset       (reset),
        .store_write (store_write),
        .write_data  (load_data),
        .write_index (write_index),
        .read_key_lo (query_key[3:0]),
        .read_key_hi (query_key[7:4]),
        .scan_high   (scan_high),
        .slot        (slot),
        .fill_lo     (fill_lo),
        .fill_hi     (fill_hi),
        .read_index  (read_index)
    );

    distance_rank u_rank (
        .clk             (clk),
        .reset           (reset),
        .query_data      (query_key),
        .candidate_valid (candidate_valid),
        .candidate_high  (scan_high),
        .candidate       (read_data),
        .rank_clear      (rank_clear),
        .rank_finish     (rank_finish),
        .match_count     (match_count),
        .match0          (match0),
        .match1          (match1),
        .match2          (match2),
        .dist0           (dist0),
        .dist1           (dist1),
        .dist2           (dist2)
    );

endmodule

`default_nettype wire

// File: rtl/hash_search_pkg.sv
`default_nettype none

package hash_search_pkg;

    localparam int pattern_w    = 8;
    localparam int nibble_w     = 4;
    localparam int store_depth  = 256;
    localparam int index_w      = 8;
    localparam int bucket_count = 16;
    localparam int bucket_slots = 16;
    localparam int slot_w       = 4;
    localparam int fill_w       = 5;    // 0 to bucket_slots.
    localparam int dist_w       = 4;    // 0 to pattern_w.
    localparam int rank_depth   = 3;
    localparam int count_w      = 2;    // 0 to rank_depth.

    localparam int state_w = 3;
    localparam logic [state_w-1:0] st_idle    = 3'd0;
    localparam logic [state_w-1:0] st_scan_lo = 3'd1;
    localparam logic [state_w-1:0] st_scan_hi = 3'd2;
    localparam logic [state_w-1:0] st_drain   = 3'd3;
    localparam logic [state_w-1:0] st_finish  = 3'd4;

    // one byte, or its two hash keys.
    typedef union packed {
        logic [pattern_w-1:0] word;
        struct packed {
            logic [nibble_w-1:0] hi;
            logic [nibble_w-1:0] lo;
        } nib;
    } pattern_word_t;

endpackage

`default_nettype wire

// File: rtl/pattern_store.sv
`timescale 1ns/10ps
`default_nettype none

module pattern_store (
    input  logic                                  clk,
    input  logic                                  store_write,
    input  logic [hash_search_pkg::index_w-1:0]   write_index,
    input  logic [hash_search_pkg::pattern_w-1:0] write_data,
    input  logic [hash_search_pkg::index_w-1:0]   read_index,
    output logic [hash_search_pkg::pattern_w-1:0] read_data
);

    logic [hash_search_pkg::pattern_w-1:0] mem [hash_search_pkg::store_depth];

    always_ff @(posedge clk)
    begin
        if (store_write)
        begin
            mem[write_index] <= write_data;
        end
        read_data <= mem[read_index];    // pattern arrives one cycle after its slot.
    end

endmodule

`default_nettype wire

// File: rtl/search_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module search_fsm (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  load_valid,
    input  logic                                  query_start,
    input  logic [hash_search_pkg::pattern_w-1:0] query_data,
    input  logic [hash_search_pkg::fill_w-1:0]    fill_lo,
    input  logic [hash_search_pkg::fill_w-1:0]    fill_hi,
    input  logic                                  active,
    input  logic                                  last,
    output logic                                  store_write,
    output logic [hash_search_pkg::index_w-1:0]   write_index,
    output logic                                  entry_full,
    output logic [hash_search_pkg::pattern_w-1:0] query_key,
    output logic                                  count_start,
    output logic [hash_search_pkg::fill_w-1:0]    count_fill,
    output logic                                  scan_high,
    output logic                                  candidate_valid,
    output logic                                  rank_clear,
    output logic                                  rank_finish,
    output logic                                  busy,
    output logic                                  done
);

    logic [hash_search_pkg::state_w-1:0] state;
    logic setup;       // first query cycle, fill counts now follow query_key.
    logic query_ok;
    logic lo_done;
    logic hi_empty;

    assign busy        = (state != hash_search_pkg::st_idle) || done;
    assign query_ok    = !busy && query_start;
    assign store_write = !busy && load_valid && !entry_full;
    assign rank_clear  = query_ok;
    assign rank_finish = (state == hash_search_pkg::st_finish);

    assign hi_empty = (fill_hi == '0);
    assign lo_done  = setup ? (fill_lo == '0) : last;

    // the counter runs the low bucket, then is reloaded for the high one.
    assign count_start = (state == hash_search_pkg::st_scan_lo) && (setup || lo_done);
    assign count_fill  = lo_done ? fill_hi : fill_lo;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            write_index <= '0;
            entry_full  <= 1'b0;
        end
        else if (store_write)
        begin
            {entry_full, write_index} <= {1'b0, write_index} + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (query_ok)
        begin
            query_key <= query_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state           <= hash_search_pkg::st_idle;
            setup           <= 1'b0;
            scan_high       <= 1'b0;
            candidate_valid <= 1'b0;
            done            <= 1'b0;
        end
        else
        begin
            setup           <= query_ok;
            candidate_valid <= active;    // lines up with the store read.
            done            <= (state == hash_search_pkg::st_finish);
            case (state)
                hash_search_pkg::st_idle:
                begin
                    if (query_ok)
                    begin
                        state     <= hash_search_pkg::st_scan_lo;
                        scan_high <= 1'b0;
                    end
                end
                hash_search_pkg::st_scan_lo:
                begin
                    if (lo_done && hi_empty)
                    begin
                        state <= hash_search_pkg::st_drain;
                    end
                    else if (lo_done)
                    begin
                        state     <= hash_search_pkg::st_scan_hi;
                        scan_high <= 1'b1;
                    end
                end
                hash_search_pkg::st_scan_hi:
                begin
                    if (last)
                    begin
                        state <= hash_search_pkg::st_drain;
                    end
                end
                hash_search_pkg::st_drain:
                begin
                    state <= hash_search_pkg::st_finish;    // last candidate is ranked here.
                end
                default:
                begin
                    state <= hash_search_pkg::st_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/slot_counter.sv
`timescale 1ns/10ps
`default_nettype none

module slot_counter (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               count_start,
    input  logic [hash_search_pkg::fill_w-1:0] count_fill,
    output logic [hash_search_pkg::slot_w-1:0] slot,
    output logic                               active,
    output logic                               last
);

    logic [hash_search_pkg::fill_w-1:0] fill_q;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            slot   <= '0;
            fill_q <= '0;
            active <= 1'b0;
        end
        else if (count_start)
        begin
            slot   <= '0;
            fill_q <= count_fill;
            active <= (count_fill != '0);    // an empty bucket issues nothing.
        end
        else if (active)
        begin
            slot   <= slot + 1'b1;
            active <= !last;
        end
    end

    assign last = active && ({1'b0, slot} == fill_q - 1'b1);

endmodule

`default_nettype wire

// File: verif/hash_search_assert.sv
`timescale 1ns/10ps
`default_nettype none

module hash_search_assert (
    input logic clk,
    input logic reset,
    input logic busy,
    input logic done
);

    logic [5:0] busy_run;    // busy cycles before this one.

    always_ff @(posedge clk)
    begin
        if (reset || !busy)
        begin
            busy_run <= '0;
        end
        else
        begin
            busy_run <= busy_run + 1'b1;
        end
    end

    done_single: assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else $error("done held high for more than one cycle");

    reset_idle: assert property (@(posedge clk) reset |=> !busy)
        else $error("busy high right after reset");

    done_in_busy: assert property (@(posedge clk) disable iff (reset) done |-> $past(busy))
        else $error("done seen without a busy cycle before it");

    busy_bound: assert property (@(posedge clk) disable iff (reset) busy |-> busy_run < 6'd36)
        else $error("busy lasted longer than 36 cycles");

endmodule

`default_nettype wire

// File: verif/tb_hash_search.sv
`timescale 1ns/10ps
`default_nettype none

module tb_hash_search;

    localparam int load_cycles  = 120 + 30 + 20 + 40 + 276;
    localparam int query_cycles = (1 + 40 + 8 + 10 + 15 + 20) * 40;
    localparam int reset_cycles = 6 * 6;
    localparam int cycle_limit  = (load_cycles + query_cycles + reset_cycles) * 12 / 10;

    logic                                  clk;
    logic                                  reset;
    logic                                  load_valid;
    logic [hash_search_pkg::pattern_w-1:0] load_data;
    logic                                  query_start;
    logic [hash_search_pkg::pattern_w-1:0] query_data;
    logic                                  busy;
    logic                                  done;
    logic [hash_search_pkg::count_w-1:0]   match_count;
    logic [hash_search_pkg::pattern_w-1:0] match0;
    logic [hash_search_pkg::pattern_w-1:0] match1;
    logic [hash_search_pkg::pattern_w-1:0] match2;
    logic [hash_search_pkg::dist_w-1:0]    dist0;
    logic [hash_search_pkg::dist_w-1:0]    dist1;
    logic [hash_search_pkg::dist_w-1:0]    dist2;

    // reference model of the store and both hash tables.
    int         model_count;
    logic [7:0] model_mem [256];
    bit         lo_indexed [256];
    int         lo_fill [16];
    int         hi_fill [16];
    int         lo_tab [16][16];
    int         hi_tab [16][16];
    int         exp_count;
    logic [7:0] exp_pat [3];
    int         exp_dist [3];
    int         checks;
    int         errors;
    int         test_checks;
    int         test_errors;
    int         cycles;

    hash_search dut (
        .clk         (clk),
        .reset       (reset),
        .load_valid  (load_valid),
        .load_data   (load_data),
        .query_start (query_start),
        .query_data  (query_data),
        .busy        (busy),
        .done        (done),
        .match_count (match_count),
        .match0      (match0),
        .match1      (match1),
        .match2      (match2),
        .dist0       (dist0),
        .dist1       (dist1),
        .dist2       (dist2)
    );

    bind hash_search hash_search_assert u_assert (
        .clk   (clk),
        .reset (reset),
        .busy  (busy),
        .done  (done)
    );

    always #20 clk = ~clk;

    always @(posedge clk)
    begin
        cycles++;
        if (cycles > cycle_limit)
        begin
            $display("timeout after %0d cycles, a search never finished", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    function automatic logic [7:0] random_byte();
        logic [31:0] r;
        r = $urandom;
        return r[7:0];
    endfunction

    task automatic expect_equal(input string name, input int got, input int exp);
        checks++;
        assert (got == exp)
        else
        begin
            errors++;
            $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic apply_reset();
        reset       = 1'b1;
        load_valid  = 1'b0;
        query_start = 1'b0;
        model_count = 0;
        for (int k = 0; k < 16; k++)
        begin
            lo_fill[k] = 0;
            hi_fill[k] = 0;
        end
        for (int e = 0; e < 256; e++)
        begin
            lo_indexed[e] = 1'b0;
        end
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;
    endtask

    task automatic record_load(input logic [7:0] data);
        int lo;
        int hi;
        lo = int'(data[3:0]);
        hi = int'(data[7:4]);
        if (model_count >= 256)
        begin
            return;    // load dropped once the store is full.
        end
        model_mem[model_count] = data;
        if (lo_fill[lo] < 16)
        begin
            lo_tab[lo][lo_fill[lo]] = model_count;
            lo_indexed[model_count] = 1'b1;
            lo_fill[lo]++;
        end
        if (hi_fill[hi] < 16)
        begin
            hi_tab[hi][hi_fill[hi]] = model_count;
            hi_fill[hi]++;
        end
        model_count++;
    endtask

    task automatic load_pattern(input logic [7:0] data);
        load_valid = 1'b1;
        load_data  = data;
        record_load(data);
        @(posedge clk);
        #2;
        load_valid = 1'b0;
    endtask

    // keeps the three closest and never lets an equal distance displace a kept entry.
    task automatic rank_candidate(input logic [7:0] p, input logic [7:0] q);
        int d;
        int pos;
        d   = $countones(p ^ q);
        pos = 0;
        while (pos < exp_count && d >= exp_dist[pos])
        begin
            pos++;
        end
        if (pos < 3)
        begin
            for (int j = 2; j > pos; j--)
            begin
                exp_pat[j]  = exp_pat[j-1];
                exp_dist[j] = exp_dist[j-1];
            end
            exp_pat[pos]  = p;
            exp_dist[pos] = d;
            if (exp_count < 3)
            begin
                exp_count++;
            end
        end
    endtask

    task automatic predict_matches(input logic [7:0] q);
        int lo;
        int hi;
        lo        = int'(q[3:0]);
        hi        = int'(q[7:4]);
        exp_count = 0;
        for (int s = 0; s < lo_fill[lo]; s++)
        begin
            rank_candidate(model_mem[lo_tab[lo][s]], q);
        end
        for (int s = 0; s < hi_fill[hi]; s++)
        begin
            if (model_mem[hi_tab[hi][s]][3:0] != q[3:0])    // seen in the low bucket.
            begin
                rank_candidate(model_mem[hi_tab[hi][s]], q);
            end
        end
    endtask

    task automatic run_query(input logic [7:0] q, input bit noisy);
        logic [31:0] r;
        logic [7:0]  got_pat [3];
        logic [3:0]  got_dist [3];
        while (busy)
        begin
            @(posedge clk);    // the done cycle still counts as busy.
            #2;
        end
        predict_matches(q);
        query_data  = q;
        query_start = 1'b1;
        @(posedge clk);
        #2;
        query_start = 1'b0;
        while (!done)
        begin
            if (noisy && busy)
            begin
                r           = $urandom;    // all of these must be ignored.
                load_valid  = r[0];
                query_start = r[1];
                load_data   = r[15:8];
                query_data  = r[23:16];
            end
            @(posedge clk);
            #2;
        end
        load_valid  = 1'b0;
        query_start = 1'b0;
        got_pat[0]  = match0;
        got_pat[1]  = match1;
        got_pat[2]  = match2;
        got_dist[0] = dist0;
        got_dist[1] = dist1;
        got_dist[2] = dist2;
        expect_equal("match_count", int'(match_count), exp_count);
        for (int i = 0; i < exp_count; i++)
        begin
            expect_equal($sformatf("match%0d", i), int'(got_pat[i]), int'(exp_pat[i]));
            expect_equal($sformatf("dist%0d", i), int'(got_dist[i]), exp_dist[i]);
        end
    endtask

    task automatic finish_test(input string name);
        $display("test %-14s %0d checks, %0d errors", name, checks - test_checks,
                 errors - test_errors);
        test_checks = checks;
        test_errors = errors;
    endtask

    initial
    begin
        logic [7:0] pick;
        int         key;
        int         idx;
        clk         = 1'b0;
        reset       = 1'b1;
        load_valid  = 1'b0;
        load_data   = '0;
        query_start = 1'b0;
        query_data  = '0;
        checks      = 0;
        errors      = 0;
        test_checks = 0;
        test_errors = 0;
        cycles      = 0;
        void'($urandom(24646));

        apply_reset();
        run_query(random_byte(), 1'b0);
        finish_test("empty_store");

        apply_reset();
        repeat (120) load_pattern(random_byte());
        repeat (40) run_query(random_byte(), 1'b0);
        finish_test("random_query");

        apply_reset();
        repeat (30) load_pattern(random_byte());
        repeat (8)
        begin
            idx = $urandom_range(29, 0);
            if (!lo_indexed[idx])
            begin
                idx = 0;    // entry 0 always has room.
            end
            run_query(model_mem[idx], 1'b0);
            expect_equal("match0", int'(match0), int'(model_mem[idx]));
            expect_equal("dist0", int'(dist0), 0);
        end
        finish_test("exact_match");

        apply_reset();
        key = $urandom_range(15, 0);
        repeat (20)
        begin
            pick = random_byte();
            load_pattern({pick[7:4], key[3:0]});
        end
        repeat (10)
        begin
            pick = random_byte();
            run_query({pick[7:4], key[3:0]}, 1'b0);
        end
        finish_test("bucket_overflow");

        apply_reset();
        repeat (40) load_pattern(random_byte());
        repeat (10) run_query(random_byte(), 1'b1);
        expect_equal("write_index", int'(dut.u_fsm.write_index), model_count);
        repeat (5) run_query(random_byte(), 1'b0);
        finish_test("busy_ignore");

        apply_reset();
        repeat (276) load_pattern(random_byte());
        expect_equal("entry_full", int'(dut.u_fsm.entry_full), 1);
        expect_equal("write_index", int'(dut.u_fsm.write_index), 0);
        repeat (20) run_query(random_byte(), 1'b0);
        finish_test("full_store");

        $display("total %0d checks, %0d errors", checks, errors);
        if (errors == 0)
        begin
            $display("Regression passed");
        end
        else
        begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
